// ==== compile.f ====
+incdir+src
+incdir+verif
src/video_pkg.sv
src/bus_pkg.sv
src/scan_if.sv
src/sprite_scene_if.sv
src/raster_timing.sv
src/sprite_regs.sv
src/enemy_sprite.sv
src/maze_video_top.sv
verif/tb_maze_video.sv

// ==== Makefile ====
# Verilator build and run of the maze video testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP ?= tb_maze_video
FILE_LIST ?= compile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0 --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "No result in $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_reference.svh ====
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

// Register words as last written by the host, index is byte address / 4
logic [31:0] model_word [10] = '{default: '0};
// Model as it stood at the previous clock edge
logic [31:0] snapshot_word [10] = '{default: '0};
// Settings of the frame on screen
logic [31:0] scene_word [10] = '{default: '0};

// Word index of a mapped address, -1 when unmapped
function automatic int map_index(input logic [7:0] addr);
  if (addr[1:0] != 2'b00 || addr > `REG_BG) begin
    return -1;
  end
  return int'(addr >> 2);
endfunction

// Bits that exist in each register
function automatic logic [31:0] field_mask(input int idx);
  if (idx == 0) begin
    return 32'h0000_000F;
  end else if (idx <= `NUM_ENEMIES) begin
    // y in 24:16, x in 8:0
    return 32'h01FF_01FF;
  end
  return 32'h0000_0FFF;
endfunction

// Expected read data, unmapped reads as 0
function automatic logic [31:0] model_read(input logic [7:0] addr);
  int idx;
  idx = map_index(addr);
  if (idx < 0) begin
    return '0;
  end
  return model_word[4'(idx)];
endfunction

// Byte lanes with strobe low keep the old value
task automatic model_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
  int idx;
  logic [31:0] merged;
  idx = map_index(addr);
  if (idx >= 0) begin
    merged = model_word[4'(idx)];
    for (int b = 0; b < 4; b++) begin
      if (strb[2'(b)]) begin
        merged[8*b +: 8] = data[8*b +: 8];
      end
    end
    model_word[4'(idx)] = merged & field_mask(idx);
  end
endtask

task automatic take_snapshot();
  snapshot_word = model_word;
endtask

// New frame picks up what the DUT latched at its origin
task automatic copy_scene();
  scene_word = snapshot_word;
endtask

// Colour of a visible pixel, red checked first
function automatic logic [11:0] expected_rgb(input logic [7:0] px, input logic [8:0] py);
  int dx;
  int dy;
  logic [3:0] en;
  en = scene_word[0][3:0];
  for (int e = 0; e < `NUM_ENEMIES; e++) begin
    dx = int'(px) - int'(scene_word[4'(1 + e)][8:0]);
    dy = int'(py) - int'(scene_word[4'(1 + e)][24:16]);
    if (en[2'(e)] && dx >= 0 && dx < `SPRITE_W && dy >= 0 && dy < `SPRITE_H) begin
      // Transparent pixels fall through to the next enemy
      if (video_pkg::ghost_pattern[3'(dy)][3'(`SPRITE_W - 1 - dx)]) begin
        return scene_word[4'(5 + e)][11:0];
      end
    end
  end
  return scene_word[9][11:0];
endfunction

`endif

// ==== verif/tb_maze_video.sv ====
`include "video_config.svh"

module tb_maze_video;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
  localparam int AXI_TIMEOUT = 32;
  localparam logic [1:0] OKAY = 2'b00;
  localparam logic [1:0] SLVERR = 2'b10;

  logic clk;
  logic reset;
  logic [7:0] awaddr;
  logic awvalid;
  logic awready;
  logic [31:0] wdata;
  logic [3:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [7:0] araddr;
  logic arvalid;
  logic arready;
  logic [31:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic [11:0] rgb;
  logic [7:0] pixel_x;
  logic [8:0] pixel_y;
  logic de;

  int seed;
  int frames_seen;
  int sprite_x;
  int sprite_y;
  logic [11:0] exp_rgb;

  // Raster position the output stream should carry at the next edge
  int exp_x;
  int exp_y;
  logic exp_de;
  logic stream_live;

  `include "tb_reference.svh"

  maze_video_top UUT (.*);

  // 100 ns period
  always #50 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  //////////////////////////////
  // AXI4-Lite master
  //////////////////////////////

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int cycles;
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b1;
    cycles = 0;
    @(posedge clk);
    while (!(awready && wready)) begin
      cycles++;
      if (cycles > AXI_TIMEOUT) abort_run("Timeout: write address and data never accepted");
      @(posedge clk);
    end
    #1;
    awvalid = 1'b0;
    wvalid = 1'b0;
    // Model follows the accept edge
    model_write(addr, data, strb);
    cycles = 0;
    @(posedge clk);
    while (!bvalid) begin
      cycles++;
      if (cycles > AXI_TIMEOUT) abort_run("Timeout: no write response from the DUT");
      @(posedge clk);
    end
    resp = bresp;
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int cycles;
    araddr = addr;
    arvalid = 1'b1;
    rready = 1'b1;
    cycles = 0;
    @(posedge clk);
    while (!arready) begin
      cycles++;
      if (cycles > AXI_TIMEOUT) abort_run("Timeout: read address never accepted");
      @(posedge clk);
    end
    #1;
    arvalid = 1'b0;
    cycles = 0;
    @(posedge clk);
    while (!rvalid) begin
      cycles++;
      if (cycles > AXI_TIMEOUT) abort_run("Timeout: no read data from the DUT");
      @(posedge clk);
    end
    data = rdata;
    resp = rresp;
    #1;
    rready = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] exp_resp);
    logic [1:0] resp;
    axi_write(addr, data, strb, resp);
    assert (resp == exp_resp) else abort_run($sformatf(
      "** Error at %0t: write 0x%h bresp %b, expected %b", $time, addr, resp, exp_resp));
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0] resp;
    axi_read(addr, data, resp);
    assert (data == exp_data && resp == exp_resp) else abort_run($sformatf(
      "** Error at %0t: read 0x%h gave %h/%b, expected %h/%b",
      $time, addr, data, resp, exp_data, exp_resp));
  endtask

  // Position and colour of one enemy
  task automatic place_enemy(input int e, input int x, input int y, input logic [11:0] color);
    write_reg(8'(`REG_POS_BASE + 4 * e), (32'(y) << 16) | 32'(x), 4'hF, OKAY);
    write_reg(8'(`REG_COLOR_BASE + 4 * e), 32'(color), 4'hF, OKAY);
  endtask

  //////////////////////////////
  // Frame and line waits
  //////////////////////////////

  task automatic wait_frames(input int n);
    int target;
    int cycles;
    target = frames_seen + n;
    cycles = 0;
    // Counter polled at the falling edge between its updates
    while (frames_seen < target) begin
      @(negedge clk);
      cycles++;
      if (cycles > n * FRAME_CYCLES + 16) abort_run("Timeout: no frame boundary on the output");
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_line(input int line);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!(de && int'(pixel_y) == line)) begin
      cycles++;
      if (cycles > FRAME_CYCLES) abort_run("Timeout: output line never reached");
      @(posedge clk);
    end
    #1;
  endtask

  //////////////////////////////
  // Pixel comparison
  //////////////////////////////

  always @(posedge clk) begin
    if (!reset) begin
      // Output trails the scan by one clock from the origin
      if (stream_live) begin
        exp_de = (exp_x < `H_ACTIVE) && (exp_y < `V_ACTIVE);
        assert (int'(pixel_x) == exp_x && int'(pixel_y) == exp_y && de == exp_de)
          else abort_run($sformatf(
            "** Error at %0t: output (%0d, %0d) de %b, expected (%0d, %0d) de %b",
            $time, pixel_x, pixel_y, de, exp_x, exp_y, exp_de));
        exp_x++;
        if (exp_x == `H_TOTAL) begin
          exp_x = 0;
          exp_y = (exp_y + 1) % `V_TOTAL;
        end
      end
      stream_live = 1'b1;
      if (de) begin
        exp_rgb = expected_rgb(pixel_x, pixel_y);
        assert (rgb == exp_rgb) else abort_run($sformatf(
          "** Error at %0t: pixel (%0d, %0d) rgb %h, expected %h",
          $time, pixel_x, pixel_y, rgb, exp_rgb));
        // Origin pixel was drawn with the old set
        if (pixel_x == '0 && pixel_y == '0) begin
          copy_scene();
          frames_seen++;
        end
      end else begin
        assert (rgb == 12'h000) else abort_run($sformatf(
          "** Error at %0t: rgb %h while de is low", $time, rgb));
      end
      take_snapshot();
    end else begin
      // First edge out of reset still shows the reset values
      exp_x = 0;
      exp_y = 0;
      stream_live = 1'b0;
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    seed = 32'he6b6;
    frames_seen = 0;
    clk = 1'b0;
    reset = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (4) @(posedge clk);
    // Quiet outputs in reset
    assert (!de && !bvalid && !rvalid) else abort_run($sformatf(
      "** Error at %0t: de %b bvalid %b rvalid %b during reset", $time, de, bvalid, rvalid));
    #1;
    reset = 1'b0;
    for (int a = 0; a <= `REG_BG; a += 4) begin
      check_reg(8'(a), 32'h0, OKAY);
    end

    // Readback of full words
    for (int a = 0; a <= `REG_BG; a += 4) begin
      write_reg(8'(a), $random(seed), 4'hF, OKAY);
      check_reg(8'(a), model_read(8'(a)), OKAY);
    end
    // Partial strobes
    write_reg(`REG_BG, 32'h0000_0ABC, 4'b0010, OKAY);
    check_reg(`REG_BG, model_read(`REG_BG), OKAY);
    write_reg(8'(`REG_POS_BASE + 4), 32'h0155_00AA, 4'b0100, OKAY);
    check_reg(8'(`REG_POS_BASE + 4), model_read(8'(`REG_POS_BASE + 4)), OKAY);
    // Unmapped addresses beyond the end and misaligned
    write_reg(8'h28, 32'hFFFF_FFFF, 4'hF, SLVERR);
    check_reg(8'h28, 32'h0, SLVERR);
    write_reg(8'h06, 32'hFFFF_FFFF, 4'hF, SLVERR);
    check_reg(8'h06, 32'h0, SLVERR);
    for (int a = 0; a <= `REG_BG; a += 4) begin
      check_reg(8'(a), model_read(8'(a)), OKAY);
    end

    // One enemy at a time with the last two clipped at the edges
    write_reg(`REG_BG, 32'h0000_0123, 4'hF, OKAY);
    for (int t = 0; t < 6; t++) begin
      if (t < 4) begin
        sprite_x = $unsigned($random(seed)) % `H_ACTIVE;
        sprite_y = $unsigned($random(seed)) % `V_ACTIVE;
      end else begin
        sprite_x = `H_ACTIVE - 1 - 2 * (5 - t);
        sprite_y = `V_ACTIVE - 1 - 4 * (5 - t);
      end
      place_enemy(t % 4, sprite_x, sprite_y, 12'($random(seed)));
      write_reg(`REG_CTRL, 32'(1) << (t % 4), 4'hF, OKAY);
      wait_frames(2);
    end

    // Overlapping stack with red on top
    place_enemy(0, 100, 100, 12'hF00);
    place_enemy(1, 103, 102, 12'hFBF);
    place_enemy(2, 98, 104, 12'h0FF);
    place_enemy(3, 105, 105, 12'hFB5);
    write_reg(`REG_CTRL, 32'h0000_000F, 4'hF, OKAY);
    wait_frames(2);

    // Move in mid-frame shows from the next frame only
    place_enemy(0, 50, 60, 12'hF00);
    write_reg(`REG_CTRL, 32'h0000_0001, 4'hF, OKAY);
    wait_frames(2);
    wait_line(120);
    write_reg(8'(`REG_POS_BASE), (32'd200 << 16) | 32'd50, 4'hF, OKAY);
    wait_frames(2);

    // All on screen with none enabled
    place_enemy(1, 20, 30, 12'hFBF);
    place_enemy(2, 60, 70, 12'h0FF);
    place_enemy(3, 110, 150, 12'hFB5);
    write_reg(`REG_CTRL, 32'h0000_0000, 4'hF, OKAY);
    wait_frames(2);

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== src/maze_video_top.sv ====
`include "video_config.svh"

module maze_video_top (
  input logic clk,
  input logic reset,
  // AXI4-Lite slave
  input logic [`AXI_ADDR_W-1:0] awaddr,
  input logic awvalid,
  output logic awready,
  input logic [`AXI_DATA_W-1:0] wdata,
  input logic [`AXI_DATA_W/8-1:0] wstrb,
  input logic wvalid,
  output logic wready,
  output logic [1:0] bresp,
  output logic bvalid,
  input logic bready,
  input logic [`AXI_ADDR_W-1:0] araddr,
  input logic arvalid,
  output logic arready,
  output logic [`AXI_DATA_W-1:0] rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input logic rready,
  // Pixel stream
  output logic [11:0] rgb,
  output logic [7:0] pixel_x,
  output logic [8:0] pixel_y,
  output logic de
);

  scan_if scan ();
  sprite_scene_if scene ();

  raster_timing u_timing (
    .clk (clk),
    .reset (reset),
    .scan (scan)
  );

  // Host registers, shadowed into the scene at frame start
  sprite_regs u_regs (
    .clk (clk),
    .reset (reset),
    .awaddr (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata (wdata),
    .wstrb (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata (rdata),
    .rresp (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .frame_start (scan.frame_start),
    .scene (scene)
  );

  enemy_sprite u_sprite (
    .clk (clk),
    .reset (reset),
    .scan (scan),
    .scene (scene),
    .rgb (rgb),
    .pixel_x (pixel_x),
    .pixel_y (pixel_y),
    .de (de)
  );

endmodule

// ==== src/enemy_sprite.sv ====
`include "video_config.svh"

module enemy_sprite (
  input logic clk,
  input logic reset,
  scan_if.sink scan,
  sprite_scene_if.sink scene,
  output video_pkg::rgb12_t rgb,
  output video_pkg::coord_x_t pixel_x,
  output video_pkg::coord_y_t pixel_y,
  output logic de
);

  // Index widths inside the sprite
  localparam int COL_W = $clog2(`SPRITE_W);
  localparam int ROW_W = $clog2(`SPRITE_H);
  localparam logic [COL_W-1:0] COL_LAST = COL_W'(`SPRITE_W - 1);

  // Opaque pixel of each enemy at the current scan position
  logic [`NUM_ENEMIES-1:0] hit;
  logic win;
  video_pkg::enemy_id_e win_id;
  video_pkg::rgb12_t pix_color;

  //////////////////////////////
  // Per-enemy hit test
  //////////////////////////////

  always_comb begin
    video_pkg::sprite_coord_t sx_ext;
    video_pkg::sprite_coord_t dx;
    video_pkg::sprite_coord_t dy;
    video_pkg::sprite_row_t row_bits;
    logic in_box;
    sx_ext = {1'b0, scan.sx};
    for (int i = 0; i < `NUM_ENEMIES; i++) begin
      // Offset inside the sprite box
      dx = sx_ext - scene.pos[i].x;
      dy = scan.sy - scene.pos[i].y;
      // Lower bound checks guard against wrapped offsets
      in_box = (sx_ext >= scene.pos[i].x) && (dx < `SPRITE_W)
            && (scan.sy >= scene.pos[i].y) && (dy < `SPRITE_H);
      row_bits = video_pkg::ghost_pattern[dy[ROW_W-1:0]];
      // Column 0 sits in the top bit
      hit[i] = scene.enable[i] && in_box && row_bits[COL_LAST - dx[COL_W-1:0]];
    end
  end

  //////////////////////////////
  // Priority and transparency
  //////////////////////////////

  // Walk from lowest to highest priority, last hit wins
  always_comb begin
    win = 1'b0;
    win_id = video_pkg::ENEMY_RED;
    for (int i = `NUM_ENEMIES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        win = 1'b1;
        win_id = video_pkg::enemy_id_e'(i);
      end
    end
  end

  // Background through transparent pixels
  assign pix_color = win ? scene.color[win_id] : scene.bg;

  //////////////////////////////
  // Output stage
  //////////////////////////////

  // Colour and coordinates stay aligned, one clock behind the scan
  always_ff @(posedge clk) begin
    if (reset) begin
      rgb <= '0;
      pixel_x <= '0;
      pixel_y <= '0;
      de <= 1'b0;
    end else begin
      de <= scan.active;
      pixel_x <= scan.sx;
      pixel_y <= scan.sy;
      // Blank outside the visible area
      rgb <= scan.active ? pix_color : '0;
    end
  end

  // Blanking holds through and after reset
  a_blank_when_no_de: assert property (
    @(posedge clk)
    !de |-> (rgb == '0)
  );

endmodule

// ==== src/sprite_regs.sv ====
`include "video_config.svh"

module sprite_regs (
  input logic clk,
  input logic reset,
  // AXI4-Lite write address / data / response
  input logic [`AXI_ADDR_W-1:0] awaddr,
  input logic awvalid,
  output logic awready,
  input logic [`AXI_DATA_W-1:0] wdata,
  input logic [`AXI_DATA_W/8-1:0] wstrb,
  input logic wvalid,
  output logic wready,
  output bus_pkg::axi_resp_e bresp,
  output logic bvalid,
  input logic bready,
  // AXI4-Lite read address / data
  input logic [`AXI_ADDR_W-1:0] araddr,
  input logic arvalid,
  output logic arready,
  output logic [`AXI_DATA_W-1:0] rdata,
  output bus_pkg::axi_resp_e rresp,
  output logic rvalid,
  input logic rready,
  input logic frame_start,
  sprite_scene_if.source scene
);

  // Working copy, written by the host
  logic [`NUM_ENEMIES-1:0] ctrl_q;
  video_pkg::sprite_pos_t pos_q [`NUM_ENEMIES];
  video_pkg::rgb12_t color_q [`NUM_ENEMIES];
  video_pkg::rgb12_t bg_q;

  bus_pkg::reg_sel_e wr_sel;
  bus_pkg::reg_sel_e rd_sel;
  logic [`AXI_DATA_W-1:0] wr_word;
  logic wr_fire;
  logic rd_fire;

  // Address to register index
  function automatic bus_pkg::reg_sel_e decode(input logic [`AXI_ADDR_W-1:0] addr);
    case (addr)
      `REG_CTRL: return bus_pkg::SEL_CTRL;
      `REG_POS_BASE: return bus_pkg::SEL_POS0;
      `REG_POS_BASE + 8'd4: return bus_pkg::SEL_POS1;
      `REG_POS_BASE + 8'd8: return bus_pkg::SEL_POS2;
      `REG_POS_BASE + 8'd12: return bus_pkg::SEL_POS3;
      `REG_COLOR_BASE: return bus_pkg::SEL_COLOR0;
      `REG_COLOR_BASE + 8'd4: return bus_pkg::SEL_COLOR1;
      `REG_COLOR_BASE + 8'd8: return bus_pkg::SEL_COLOR2;
      `REG_COLOR_BASE + 8'd12: return bus_pkg::SEL_COLOR3;
      `REG_BG: return bus_pkg::SEL_BG;
      default: return bus_pkg::SEL_INVALID;
    endcase
  endfunction

  // Which enemy a position or colour register belongs to
  function automatic video_pkg::enemy_id_e enemy_of(input bus_pkg::reg_sel_e sel);
    case (sel)
      bus_pkg::SEL_POS1, bus_pkg::SEL_COLOR1: return video_pkg::ENEMY_PINK;
      bus_pkg::SEL_POS2, bus_pkg::SEL_COLOR2: return video_pkg::ENEMY_BLUE;
      bus_pkg::SEL_POS3, bus_pkg::SEL_COLOR3: return video_pkg::ENEMY_YELLOW;
      default: return video_pkg::ENEMY_RED;
    endcase
  endfunction

  // Bus view of a register, unmapped reads as 0
  function automatic logic [`AXI_DATA_W-1:0] reg_word(input bus_pkg::reg_sel_e sel);
    video_pkg::enemy_id_e e;
    e = enemy_of(sel);
    case (sel)
      bus_pkg::SEL_CTRL: return `AXI_DATA_W'(ctrl_q);
      bus_pkg::SEL_POS0, bus_pkg::SEL_POS1, bus_pkg::SEL_POS2, bus_pkg::SEL_POS3:
        // y in 24:16, x in 8:0
        return {7'd0, pos_q[e].y, 7'd0, pos_q[e].x};
      bus_pkg::SEL_COLOR0, bus_pkg::SEL_COLOR1, bus_pkg::SEL_COLOR2, bus_pkg::SEL_COLOR3:
        return `AXI_DATA_W'(color_q[e]);
      bus_pkg::SEL_BG: return `AXI_DATA_W'(bg_q);
      default: return '0;
    endcase
  endfunction

  // Byte lanes with strobe low keep the old value
  function automatic logic [`AXI_DATA_W-1:0] apply_strb(
    input logic [`AXI_DATA_W-1:0] old_word,
    input logic [`AXI_DATA_W-1:0] new_word,
    input logic [`AXI_DATA_W/8-1:0] strb
  );
    logic [`AXI_DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < `AXI_DATA_W / 8; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  assign wr_sel = decode(awaddr);
  assign rd_sel = decode(araddr);

  // Read-modify-write value for the addressed register
  always_comb begin
    wr_word = apply_strb(reg_word(wr_sel), wdata, wstrb);
  end

  assign wr_fire = awvalid && awready && wvalid && wready;
  assign rd_fire = arvalid && arready;

  //////////////////////////////
  // Write channel
  //////////////////////////////

  // Ready pulses one cycle after AW and W are both seen
  // Held off while a response is still pending
  always_ff @(posedge clk) begin
    if (reset) begin
      awready <= 1'b0;
      wready <= 1'b0;
      bvalid <= 1'b0;
      bresp <= bus_pkg::RESP_OKAY;
    end else begin
      awready <= awvalid && wvalid && !awready && !bvalid;
      wready <= awvalid && wvalid && !awready && !bvalid;
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp <= (wr_sel == bus_pkg::SEL_INVALID) ? bus_pkg::RESP_SLVERR
                                                  : bus_pkg::RESP_OKAY;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Register file update
  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_q <= '0;
      pos_q <= '{default: '0};
      color_q <= '{default: '0};
      bg_q <= '0;
    end else if (wr_fire) begin
      case (wr_sel)
        bus_pkg::SEL_CTRL: ctrl_q <= wr_word[`NUM_ENEMIES-1:0];
        bus_pkg::SEL_POS0, bus_pkg::SEL_POS1, bus_pkg::SEL_POS2, bus_pkg::SEL_POS3: begin
          pos_q[enemy_of(wr_sel)].x <= wr_word[8:0];
          pos_q[enemy_of(wr_sel)].y <= wr_word[24:16];
        end
        bus_pkg::SEL_COLOR0, bus_pkg::SEL_COLOR1, bus_pkg::SEL_COLOR2, bus_pkg::SEL_COLOR3:
          color_q[enemy_of(wr_sel)] <= wr_word[11:0];
        bus_pkg::SEL_BG: bg_q <= wr_word[11:0];
        // Unmapped write is dropped
        default: begin
        end
      endcase
    end
  end

  //////////////////////////////
  // Read channel
  //////////////////////////////

  // arready one cycle after arvalid, data the cycle after
  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid <= 1'b0;
      rdata <= '0;
      rresp <= bus_pkg::RESP_OKAY;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
        rdata <= reg_word(rd_sel);
        rresp <= (rd_sel == bus_pkg::SEL_INVALID) ? bus_pkg::RESP_SLVERR
                                                  : bus_pkg::RESP_OKAY;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Shadow copy at frame start
  //////////////////////////////

  // Overlay sees a stable set for the whole frame
  always_ff @(posedge clk) begin
    if (reset) begin
      scene.enable <= '0;
      scene.pos <= '{default: '0};
      scene.color <= '{default: '0};
      scene.bg <= '0;
    end else if (frame_start) begin
      scene.enable <= ctrl_q;
      scene.pos <= pos_q;
      scene.color <= color_q;
      scene.bg <= bg_q;
    end
  end

  // Responses wait for the master
  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid
  );

  a_rvalid_hold: assert property (
    @(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid
  );

endmodule

// ==== src/raster_timing.sv ====
`include "video_config.svh"

module raster_timing (
  input logic clk,
  input logic reset,
  scan_if.source scan
);

  // Last count on each axis
  localparam video_pkg::coord_x_t SX_LAST = video_pkg::coord_x_t'(`H_TOTAL - 1);
  localparam video_pkg::coord_y_t SY_LAST = video_pkg::coord_y_t'(`V_TOTAL - 1);
  // First count outside the visible area
  localparam video_pkg::coord_x_t SX_ACT = video_pkg::coord_x_t'(`H_ACTIVE);
  localparam video_pkg::coord_y_t SY_ACT = video_pkg::coord_y_t'(`V_ACTIVE);

  video_pkg::coord_x_t sx_q;
  video_pkg::coord_y_t sy_q;

  // Horizontal counter steps every clock
  // Vertical counter steps at the end of each line
  always_ff @(posedge clk) begin
    if (reset) begin
      sx_q <= '0;
      sy_q <= '0;
    end else if (sx_q == SX_LAST) begin
      sx_q <= '0;
      if (sy_q == SY_LAST) begin
        sy_q <= '0;
      end else begin
        sy_q <= sy_q + 1'b1;
      end
    end else begin
      sx_q <= sx_q + 1'b1;
    end
  end

  assign scan.sx = sx_q;
  assign scan.sy = sy_q;

  // Visible area starts at the origin
  assign scan.active = (sx_q < SX_ACT) && (sy_q < SY_ACT);

  // Origin of the frame
  assign scan.frame_start = (sx_q == '0) && (sy_q == '0);

  // Origin is left on the very next pixel
  a_frame_start_pulse: assert property (
    @(posedge clk) disable iff (reset)
    scan.frame_start |=> !scan.frame_start
  );

endmodule

// ==== src/sprite_scene_if.sv ====
`include "video_config.svh"

// Enemy settings as latched at frame start
interface sprite_scene_if;

  // Indexed by video_pkg::enemy_id_e
  video_pkg::sprite_pos_t pos [`NUM_ENEMIES];
  video_pkg::rgb12_t color [`NUM_ENEMIES];
  // Bit n enables enemy n
  logic [`NUM_ENEMIES-1:0] enable;
  // Shown where no enemy is opaque
  video_pkg::rgb12_t bg;

  modport source (output pos, output color, output enable, output bg);

  modport sink (input pos, input color, input enable, input bg);

endinterface

// ==== src/scan_if.sv ====
// Raster position from the timing generator
interface scan_if;

  video_pkg::coord_x_t sx;
  video_pkg::coord_y_t sy;
  // Inside the 224 x 288 visible area
  logic active;
  // Single cycle at sx == 0, sy == 0
  logic frame_start;

  modport source (output sx, output sy, output active, output frame_start);

  modport sink (input sx, input sy, input active, input frame_start);

endinterface

// ==== src/bus_pkg.sv ====
package bus_pkg;

  // Decoded register index
  typedef enum logic [3:0] {
    SEL_CTRL,
    SEL_POS0,
    SEL_POS1,
    SEL_POS2,
    SEL_POS3,
    SEL_COLOR0,
    SEL_COLOR1,
    SEL_COLOR2,
    SEL_COLOR3,
    SEL_BG,
    // Anything off the map
    SEL_INVALID
  } reg_sel_e;

  // AXI BRESP / RRESP codes in use
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

endpackage

// ==== src/video_pkg.sv ====
`include "video_config.svh"

package video_pkg;

  // Scan position, sized to the total frame
  typedef logic [7:0] coord_x_t;
  typedef logic [8:0] coord_y_t;

  // Sprite coordinates are 9 bits on both axes
  typedef logic [8:0] sprite_coord_t;

  typedef struct packed {
    sprite_coord_t x;
    sprite_coord_t y;
  } sprite_pos_t;

  // 4 bits per channel, red in the top nibble
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb12_t;

  // Enum order is draw priority, red on top
  typedef enum logic [1:0] {
    ENEMY_RED,
    ENEMY_PINK,
    ENEMY_BLUE,
    ENEMY_YELLOW
  } enemy_id_e;

  typedef logic [`SPRITE_W-1:0] sprite_row_t;

  // Ghost shape, row 0 on top, bit 7 is the leftmost column
  localparam sprite_row_t ghost_pattern [`SPRITE_H] = '{
    8'b0011_1100,
    8'b0111_1110,
    8'b1101_1011,
    8'b1101_1011,
    8'b1111_1111,
    8'b1111_1111,
    8'b1111_1111,
    8'b1101_1011
  };

endpackage

// ==== src/video_config.svh ====
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Raster geometry, one pixel per clock
`define H_ACTIVE 224
`define H_TOTAL 256
`define V_ACTIVE 288
`define V_TOTAL 300

// Enemy sprite size in pixels
`define SPRITE_W 8
`define SPRITE_H 8
`define NUM_ENEMIES 4

// AXI4-Lite widths
`define AXI_ADDR_W 8
`define AXI_DATA_W 32

// Register map, byte addresses
`define REG_CTRL 8'h00
// One position word per enemy, stride 4
`define REG_POS_BASE 8'h04
`define REG_COLOR_BASE 8'h14
`define REG_BG 8'h24

`endif
